// ==== axil_pkg.sv ====
package axil_pkg;

   // AXI4-Lite channel widths.
   localparam int AXIL_ADDR_W = 32;  // Byte address.
   localparam int AXIL_DATA_W = 32;  // One data word.
   localparam int AXIL_ID_W   = 4;   // Echoed on B and R.

   // Only OKAY is ever returned.
   localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;  // Normal access done.

endpackage

// ==== iob_pkg.sv ====
package iob_pkg;

   localparam int IOB_ADDR_W = 32;            // Native bus address.
   localparam int IOB_DATA_W = 32;            // Native bus data.
   localparam int IOB_STRB_W = IOB_DATA_W/8;  // One strobe per byte.

   // Address word, read flat or split into fields.
   typedef union packed {
      logic [IOB_ADDR_W-1:0] raw;  // Flat byte address.
      struct packed {
         logic [15:0] unused_hi;   // Ignored.
         logic [3:0]  region;      // Target select.
         logic [5:0]  unused_mid;  // Ignored.
         logic [3:0]  index;       // Word in the target.
         logic [1:0]  offset;      // Byte in the word.
      } fields;
   } iob_addr_u;

   localparam logic [3:0] REGION_REGS  = 4'd0;  // Scratch bank.
   localparam logic [3:0] REGION_TIMER = 4'd1;  // Timer block.

   // Timer word indices.
   localparam logic [3:0] TMR_CTRL  = 4'd0;  // Bit0 enable, bit1 clear.
   localparam logic [3:0] TMR_COUNT = 4'd1;  // Running count.
   localparam logic [3:0] TMR_CMP   = 4'd2;  // Compare value.
   localparam logic [3:0] TMR_STAT  = 4'd3;  // Bit0 sticky match.

endpackage

// ==== axil2iob.sv ====
`timescale 1ns/1ps

module axil2iob import axil_pkg::*, iob_pkg::*; (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic [AXIL_ID_W-1:0]     axil_awid_i,
   input  logic [AXIL_ADDR_W-1:0]   axil_awaddr_i,
   input  logic [2:0]               axil_awprot_i,   // Ignored.
   input  logic [3:0]               axil_awqos_i,    // Ignored.
   input  logic                     axil_awvalid_i,
   output logic                     axil_awready_o,
   input  logic [AXIL_DATA_W-1:0]   axil_wdata_i,
   input  logic [AXIL_DATA_W/8-1:0] axil_wstrb_i,
   input  logic                     axil_wvalid_i,
   output logic                     axil_wready_o,
   output logic [AXIL_ID_W-1:0]     axil_bid_o,
   output logic [1:0]               axil_bresp_o,
   output logic                     axil_bvalid_o,
   input  logic                     axil_bready_i,
   input  logic [AXIL_ID_W-1:0]     axil_arid_i,
   input  logic [AXIL_ADDR_W-1:0]   axil_araddr_i,
   input  logic [2:0]               axil_arprot_i,   // Ignored.
   input  logic [3:0]               axil_arqos_i,    // Ignored.
   input  logic                     axil_arvalid_i,
   output logic                     axil_arready_o,
   output logic [AXIL_ID_W-1:0]     axil_rid_o,
   output logic [AXIL_DATA_W-1:0]   axil_rdata_o,
   output logic [1:0]               axil_rresp_o,
   output logic                     axil_rvalid_o,
   input  logic                     axil_rready_i,
   output logic                     iob_valid_o,
   input  logic                     iob_ready_i,
   output logic [IOB_ADDR_W-1:0]    iob_addr_o,
   output logic [IOB_DATA_W-1:0]    iob_wdata_o,
   output logic [IOB_STRB_W-1:0]    iob_wstrb_o,
   input  logic                     iob_rvalid_i,
   input  logic [IOB_DATA_W-1:0]    iob_rdata_i
);

   localparam logic [2:0] ST_IDLE  = 3'd0;  // Waiting for a host request.
   localparam logic [2:0] ST_REQ   = 3'd1;  // IOb request out.
   localparam logic [2:0] ST_RWAIT = 3'd2;  // Waiting for read data.
   localparam logic [2:0] ST_WRESP = 3'd3;  // B channel held.
   localparam logic [2:0] ST_RRESP = 3'd4;  // R channel held.

   logic [2:0]            state_q;
   logic                  awready_q;   // Drives both AW and W ready.
   logic                  arready_q;
   logic                  is_write_q;  // Kind of the held transaction.
   iob_addr_u             addr_q;
   logic [IOB_DATA_W-1:0] wdata_q;
   logic [IOB_STRB_W-1:0] wstrb_q;
   logic [AXIL_ID_W-1:0]  id_q;
   logic [IOB_DATA_W-1:0] rdata_q;

   // Ready pulses only in idle, so nothing new enters while a response waits.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= ST_IDLE;
         awready_q  <= 1'b0;
         arready_q  <= 1'b0;
         is_write_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (awready_q) begin            // Write handshake edge.
                  awready_q  <= 1'b0;
                  is_write_q <= 1'b1;
                  state_q    <= ST_REQ;
               end else if (arready_q) begin   // Read handshake edge.
                  arready_q  <= 1'b0;
                  is_write_q <= 1'b0;
                  state_q    <= ST_REQ;
               end else if (axil_awvalid_i && axil_wvalid_i) begin
                  awready_q <= 1'b1;           // Write wins over read.
               end else if (axil_arvalid_i) begin
                  arready_q <= 1'b1;
               end
            end
            ST_REQ: begin
               if (iob_ready_i) begin
                  state_q <= is_write_q ? ST_WRESP : ST_RWAIT;
               end
            end
            ST_RWAIT: begin
               if (iob_rvalid_i) state_q <= ST_RRESP;   // Data latched below.
            end
            ST_WRESP: begin
               if (axil_bready_i) state_q <= ST_IDLE;
            end
            ST_RRESP: begin
               if (axil_rready_i) state_q <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Payload capture.
   always_ff @(posedge clk_i) begin
      if (state_q == ST_IDLE && awready_q) begin
         addr_q.raw <= axil_awaddr_i;
         wdata_q    <= axil_wdata_i;
         wstrb_q    <= axil_wstrb_i;
         id_q       <= axil_awid_i;
      end else if (state_q == ST_IDLE && arready_q) begin
         addr_q.raw <= axil_araddr_i;
         wstrb_q    <= '0;              // Zero strobe marks a read.
         id_q       <= axil_arid_i;
      end
      if (state_q == ST_RWAIT && iob_rvalid_i) rdata_q <= iob_rdata_i;
   end

   assign axil_awready_o = awready_q;
   assign axil_wready_o  = awready_q;             // Same pulse as AW.
   assign axil_arready_o = arready_q;

   assign axil_bvalid_o  = (state_q == ST_WRESP);
   assign axil_bid_o     = id_q;
   assign axil_bresp_o   = AXIL_RESP_OKAY;
   assign axil_rvalid_o  = (state_q == ST_RRESP);
   assign axil_rid_o     = id_q;
   assign axil_rdata_o   = rdata_q;
   assign axil_rresp_o   = AXIL_RESP_OKAY;

   assign iob_valid_o = (state_q == ST_REQ);   // Held until ready.
   assign iob_addr_o  = addr_q.raw;
   assign iob_wdata_o = wdata_q;
   assign iob_wstrb_o = wstrb_q;

endmodule

// ==== iob_addr_decode.sv ====
`timescale 1ns/1ps

module iob_addr_decode import iob_pkg::*; (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  iob_valid_i,
   output logic                  iob_ready_o,
   input  logic [IOB_ADDR_W-1:0] iob_addr_i,
   input  logic [IOB_STRB_W-1:0] iob_wstrb_i,
   output logic                  regs_valid_o,
   input  logic                  regs_ready_i,
   output logic                  tmr_valid_o,
   input  logic                  tmr_ready_i,
   output logic                  unm_rvalid_o
);

   iob_addr_u addr;
   logic      sel_regs;
   logic      sel_tmr;

   assign addr.raw = iob_addr_i;
   assign sel_regs = (addr.fields.region == REGION_REGS);
   assign sel_tmr  = (addr.fields.region == REGION_TIMER);

   assign regs_valid_o = iob_valid_i & sel_regs;
   assign tmr_valid_o  = iob_valid_i & sel_tmr;

   // Unmapped space is always ready.
   assign iob_ready_o = sel_regs ? regs_ready_i :
                        sel_tmr  ? tmr_ready_i  : 1'b1;

   // Unmapped reads still get one rvalid.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         unm_rvalid_o <= 1'b0;
      end else begin
         unm_rvalid_o <= iob_valid_i & ~sel_regs & ~sel_tmr & (iob_wstrb_i == '0);
      end
   end

endmodule

// ==== iob_reg_bank.sv ====
`timescale 1ns/1ps

module iob_reg_bank import iob_pkg::*; #(
   parameter int REG_N = 8   // Power of two, 2 to 16.
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  valid_i,
   output logic                  ready_o,
   input  logic [IOB_ADDR_W-1:0] addr_i,
   input  logic [IOB_DATA_W-1:0] wdata_i,
   input  logic [IOB_STRB_W-1:0] wstrb_i,
   output logic                  rvalid_o,
   output logic [IOB_DATA_W-1:0] rdata_o
);

   localparam int IDX_W = $clog2(REG_N);

   iob_addr_u             addr;
   logic [IDX_W-1:0]      idx;          // Index modulo REG_N.
   logic                  wr;
   logic                  rd;
   logic [IOB_DATA_W-1:0] mem_q [REG_N];

   assign addr.raw = addr_i;
   assign idx      = addr.fields.index[IDX_W-1:0];   // High index bits alias.
   assign ready_o  = 1'b1;                           // Never stalls.
   assign wr       = valid_i & ready_o & (wstrb_i != '0);
   assign rd       = valid_i & ready_o & (wstrb_i == '0);

   // Byte-merge write at the accept edge.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int i = 0; i < REG_N; i++) begin
            mem_q[i] <= '0;
         end
      end else if (wr) begin
         for (int b = 0; b < IOB_STRB_W; b++) begin
            if (wstrb_i[b]) mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= rd;   // One cycle after accept.
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd) rdata_o <= mem_q[idx];
   end

endmodule

// ==== iob_timer.sv ====
`timescale 1ns/1ps

module iob_timer import iob_pkg::*; #(
   parameter int TIMER_W = 32   // Counter width, 8 to 32.
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  valid_i,
   output logic                  ready_o,
   input  logic [IOB_ADDR_W-1:0] addr_i,
   input  logic [IOB_DATA_W-1:0] wdata_i,
   input  logic [IOB_STRB_W-1:0] wstrb_i,
   output logic                  rvalid_o,
   output logic [IOB_DATA_W-1:0] rdata_o
);

   iob_addr_u             addr;
   logic                  wr;
   logic                  rd;
   logic                  wr_b0;    // Write touching byte 0.
   logic [IOB_DATA_W-1:0] wmask;    // Strobes widened to bits.
   logic [IOB_DATA_W-1:0] rd_word;
   logic                  en_q;
   logic                  match_q;
   logic [TIMER_W-1:0]    count_q;
   logic [TIMER_W-1:0]    cmp_q;

   assign addr.raw = addr_i;
   assign ready_o  = 1'b1;
   assign wr       = valid_i & ready_o & (wstrb_i != '0);
   assign rd       = valid_i & ready_o & (wstrb_i == '0);
   assign wr_b0    = wr & wstrb_i[0];

   always_comb begin
      for (int b = 0; b < IOB_STRB_W; b++) begin
         wmask[8*b +: 8] = {8{wstrb_i[b]}};
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         en_q    <= 1'b0;
         count_q <= '0;
         cmp_q   <= '0;
         match_q <= 1'b0;
      end else begin
         if (wr_b0 && addr.fields.index == TMR_CTRL) en_q <= wdata_i[0];
         if (wr_b0 && addr.fields.index == TMR_CTRL && wdata_i[1]) begin
            count_q <= '0;                        // Clear pulse.
         end else if (en_q) begin
            count_q <= count_q + 1'b1;
         end
         if (wr && addr.fields.index == TMR_CMP) begin
            cmp_q <= (cmp_q & ~wmask[TIMER_W-1:0]) | (wdata_i[TIMER_W-1:0] & wmask[TIMER_W-1:0]);
         end
         if (en_q && count_q == cmp_q) begin
            match_q <= 1'b1;                      // Set beats clear.
         end else if (wr_b0 && addr.fields.index == TMR_STAT && wdata_i[0]) begin
            match_q <= 1'b0;                      // Write one to clear.
         end
      end
   end

   // Read word, zero-extended.
   always_comb begin
      rd_word = '0;
      case (addr.fields.index)
         TMR_CTRL:  rd_word[0]           = en_q;      // Clear reads zero.
         TMR_COUNT: rd_word[TIMER_W-1:0] = count_q;
         TMR_CMP:   rd_word[TIMER_W-1:0] = cmp_q;
         TMR_STAT:  rd_word[0]           = match_q;
         default:   rd_word              = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_o <= 1'b0;
      end else begin
         rvalid_o <= rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd) rdata_o <= rd_word;
   end

endmodule

// ==== iob_rdata_mux.sv ====
`timescale 1ns/1ps

module iob_rdata_mux import iob_pkg::*; (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  iob_valid_i,
   input  logic                  iob_ready_i,
   input  logic [IOB_ADDR_W-1:0] iob_addr_i,
   input  logic [IOB_STRB_W-1:0] iob_wstrb_i,
   input  logic                  regs_rvalid_i,
   input  logic [IOB_DATA_W-1:0] regs_rdata_i,
   input  logic                  tmr_rvalid_i,
   input  logic [IOB_DATA_W-1:0] tmr_rdata_i,
   input  logic                  unm_rvalid_i,
   output logic                  iob_rvalid_o,
   output logic [IOB_DATA_W-1:0] iob_rdata_o
);

   iob_addr_u  addr;
   logic [3:0] region_q;   // Region of the read in flight.

   assign addr.raw = iob_addr_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         region_q <= REGION_REGS;
      end else if (iob_valid_i && iob_ready_i && iob_wstrb_i == '0) begin
         region_q <= addr.fields.region;   // Latched at read accept.
      end
   end

   always_comb begin
      case (region_q)
         REGION_REGS: begin
            iob_rvalid_o = regs_rvalid_i;
            iob_rdata_o  = regs_rdata_i;
         end
         REGION_TIMER: begin
            iob_rvalid_o = tmr_rvalid_i;
            iob_rdata_o  = tmr_rdata_i;
         end
         default: begin
            iob_rvalid_o = unm_rvalid_i;   // Unmapped reads give zero.
            iob_rdata_o  = '0;
         end
      endcase
   end

endmodule

// ==== axil_regs_top.sv ====
`timescale 1ns/1ps

module axil_regs_top import axil_pkg::*, iob_pkg::*; #(
   parameter int REG_N   = 8,    // Scratch words.
   parameter int TIMER_W = 32    // Counter width.
) (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic [AXIL_ID_W-1:0]     axil_awid_i,
   input  logic [AXIL_ADDR_W-1:0]   axil_awaddr_i,
   input  logic [2:0]               axil_awprot_i,
   input  logic [3:0]               axil_awqos_i,
   input  logic                     axil_awvalid_i,
   output logic                     axil_awready_o,
   input  logic [AXIL_DATA_W-1:0]   axil_wdata_i,
   input  logic [AXIL_DATA_W/8-1:0] axil_wstrb_i,
   input  logic                     axil_wvalid_i,
   output logic                     axil_wready_o,
   output logic [AXIL_ID_W-1:0]     axil_bid_o,
   output logic [1:0]               axil_bresp_o,
   output logic                     axil_bvalid_o,
   input  logic                     axil_bready_i,
   input  logic [AXIL_ID_W-1:0]     axil_arid_i,
   input  logic [AXIL_ADDR_W-1:0]   axil_araddr_i,
   input  logic [2:0]               axil_arprot_i,
   input  logic [3:0]               axil_arqos_i,
   input  logic                     axil_arvalid_i,
   output logic                     axil_arready_o,
   output logic [AXIL_ID_W-1:0]     axil_rid_o,
   output logic [AXIL_DATA_W-1:0]   axil_rdata_o,
   output logic [1:0]               axil_rresp_o,
   output logic                     axil_rvalid_o,
   input  logic                     axil_rready_i
);

   logic                  iob_valid, iob_ready, iob_rvalid;   // Bridge side.
   logic [IOB_ADDR_W-1:0] iob_addr;
   logic [IOB_DATA_W-1:0] iob_wdata, iob_rdata;
   logic [IOB_STRB_W-1:0] iob_wstrb;
   logic                  regs_valid, regs_ready, regs_rvalid;
   logic [IOB_DATA_W-1:0] regs_rdata;
   logic                  tmr_valid, tmr_ready, tmr_rvalid;
   logic [IOB_DATA_W-1:0] tmr_rdata;
   logic                  unm_rvalid;                          // Unmapped read done.

   axil2iob u_axil2iob (
      .clk_i, .reset_i,
      .axil_awid_i, .axil_awaddr_i, .axil_awprot_i, .axil_awqos_i,
      .axil_awvalid_i, .axil_awready_o,
      .axil_wdata_i, .axil_wstrb_i, .axil_wvalid_i, .axil_wready_o,
      .axil_bid_o, .axil_bresp_o, .axil_bvalid_o, .axil_bready_i,
      .axil_arid_i, .axil_araddr_i, .axil_arprot_i, .axil_arqos_i,
      .axil_arvalid_i, .axil_arready_o,
      .axil_rid_o, .axil_rdata_o, .axil_rresp_o, .axil_rvalid_o, .axil_rready_i,
      .iob_valid_o (iob_valid),  .iob_ready_i (iob_ready),
      .iob_addr_o  (iob_addr),   .iob_wdata_o (iob_wdata),  .iob_wstrb_o (iob_wstrb),
      .iob_rvalid_i(iob_rvalid), .iob_rdata_i (iob_rdata)
   );

   iob_addr_decode u_iob_addr_decode (
      .clk_i, .reset_i,
      .iob_valid_i (iob_valid), .iob_ready_o (iob_ready),
      .iob_addr_i  (iob_addr),  .iob_wstrb_i (iob_wstrb),
      .regs_valid_o(regs_valid), .regs_ready_i(regs_ready),
      .tmr_valid_o (tmr_valid),  .tmr_ready_i (tmr_ready),
      .unm_rvalid_o(unm_rvalid)
   );

   iob_reg_bank #(.REG_N(REG_N)) u_iob_reg_bank (
      .clk_i, .reset_i,
      .valid_i (regs_valid), .ready_o (regs_ready), .addr_i (iob_addr),
      .wdata_i (iob_wdata),  .wstrb_i (iob_wstrb),
      .rvalid_o(regs_rvalid), .rdata_o(regs_rdata)
   );

   iob_timer #(.TIMER_W(TIMER_W)) u_iob_timer (
      .clk_i, .reset_i,
      .valid_i (tmr_valid), .ready_o (tmr_ready), .addr_i (iob_addr),
      .wdata_i (iob_wdata), .wstrb_i (iob_wstrb),
      .rvalid_o(tmr_rvalid), .rdata_o(tmr_rdata)
   );

   iob_rdata_mux u_iob_rdata_mux (
      .clk_i, .reset_i,
      .iob_valid_i  (iob_valid),   .iob_ready_i (iob_ready),
      .iob_addr_i   (iob_addr),    .iob_wstrb_i (iob_wstrb),
      .regs_rvalid_i(regs_rvalid), .regs_rdata_i(regs_rdata),
      .tmr_rvalid_i (tmr_rvalid),  .tmr_rdata_i (tmr_rdata),
      .unm_rvalid_i (unm_rvalid),
      .iob_rvalid_o (iob_rvalid),  .iob_rdata_o (iob_rdata)
   );

endmodule

// ==== tb_axil_regs.sv ====
`timescale 1ns/1ps

module tb_axil_regs
   import axil_pkg::*, iob_pkg::*;
();

   localparam int  REG_N      = 8;
   localparam int  TIMER_W    = 32;
   localparam time CLK_PERIOD = 100;
   localparam int  N_TRANS    = 260;                  // Upper bound over all tests.
   localparam int  WD_CYCLES  = N_TRANS * 20 + 1000;

   logic                     clk_i, reset_i;
   logic [AXIL_ID_W-1:0]     axil_awid_i, axil_arid_i, axil_bid_o, axil_rid_o;
   logic [AXIL_ADDR_W-1:0]   axil_awaddr_i, axil_araddr_i;
   logic [2:0]               axil_awprot_i, axil_arprot_i;
   logic [3:0]               axil_awqos_i, axil_arqos_i;
   logic [AXIL_DATA_W-1:0]   axil_wdata_i, axil_rdata_o;
   logic [AXIL_DATA_W/8-1:0] axil_wstrb_i;
   logic [1:0]               axil_bresp_o, axil_rresp_o;
   logic                     axil_awvalid_i, axil_awready_o, axil_wvalid_i, axil_wready_o;
   logic                     axil_bvalid_o, axil_bready_i, axil_arvalid_i, axil_arready_o;
   logic                     axil_rvalid_o, axil_rready_i;

   logic [31:0] lfsr_q = 32'h4f60f7cb;
   logic [31:0] ref_mem [REG_N];                      // Expected scratch contents.
   logic [31:0] exp_data_q[$], act_data_q[$];
   logic [3:0]  exp_id_q[$], act_id_q[$];
   logic [1:0]  exp_resp_q[$], act_resp_q[$];
   event        resp_ev;
   string       cur_test;
   int          err_cnt, test_err0, tests_run, tests_failed, checks;

   axil_regs_top #(.REG_N(REG_N), .TIMER_W(TIMER_W)) u_axil_regs_top (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // Galois LFSR, one step per bit.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      end
      return v;
   endfunction

   function automatic logic [31:0] make_addr(input logic [3:0] region, input logic [3:0] index);
      return {16'h0, region, 6'h0, index, 2'b00};     // Region at 15:12, word at 5:2.
   endfunction

   // Scratch memory with byte merge and aliasing; unmapped reads give zero.
   function automatic void ref_model(input bit wr, input logic [31:0] addr, input logic [31:0] data,
                                     input logic [3:0] strb, input logic [3:0] id,
                                     output logic [31:0] exp_data, output logic [1:0] exp_resp,
                                     output logic [3:0] exp_id);
      int w;
      w        = addr[5:2] % REG_N;
      exp_data = '0;
      if (addr[15:12] == REGION_REGS) begin
         if (wr) begin
            for (int b = 0; b < 4; b++) begin
               if (strb[b]) ref_mem[w][8*b +: 8] = data[8*b +: 8];
            end
         end else begin
            exp_data = ref_mem[w];
         end
      end
      exp_resp = AXIL_RESP_OKAY;                      // No error responses exist.
      exp_id   = id;
   endfunction

   task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
   endtask

   task automatic report_fail(input string msg);
      $display("Failure in test %s: %s", cur_test, msg);
      err_cnt++;
   endtask

   task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [3:0] id, input bit offer,
                             output logic [3:0] got_id, output logic [1:0] got_resp);
      int delay;
      delay          = rand_bits(2);                  // Low bready cycles.
      axil_awaddr_i  = addr;
      axil_awid_i    = id;
      axil_wdata_i   = data;
      axil_wstrb_i   = strb;
      axil_awvalid_i = 1'b1;
      axil_wvalid_i  = 1'b1;
      while (!axil_awready_o) @(negedge clk_i);
      if (axil_wready_o !== 1'b1) report_fail("wready did not rise together with awready");
      @(negedge clk_i);                               // Handshake edge passed.
      if (axil_awready_o !== 1'b0 || axil_wready_o !== 1'b0)
         report_fail("write address or data ready stayed high after the handshake");
      axil_awvalid_i = 1'b0;
      axil_wvalid_i  = 1'b0;
      while (!axil_bvalid_o) @(negedge clk_i);
      got_id   = axil_bid_o;
      got_resp = axil_bresp_o;
      if (offer) begin
         axil_araddr_i  = addr;                       // Competing read.
         axil_arid_i    = ~id;
         axil_arvalid_i = 1'b1;
      end
      repeat (delay) begin
         @(negedge clk_i);
         if (!axil_bvalid_o || axil_bid_o !== got_id || axil_bresp_o !== got_resp)
            report_fail("write response changed while bready was low");
         if (axil_awready_o || axil_wready_o || axil_arready_o)
            report_fail("new address accepted while a write response was held");
      end
      axil_bready_i = 1'b1;
      @(negedge clk_i);
      axil_bready_i  = 1'b0;
      axil_arvalid_i = 1'b0;
   endtask

   task automatic axil_read(input logic [31:0] addr, input logic [3:0] id, input bit offer,
                            output logic [31:0] got_data, output logic [3:0] got_id,
                            output logic [1:0] got_resp);
      int delay;
      delay          = rand_bits(2);                  // Low rready cycles.
      axil_araddr_i  = addr;
      axil_arid_i    = id;
      axil_arvalid_i = 1'b1;
      while (!axil_arready_o) @(negedge clk_i);
      @(negedge clk_i);
      axil_arvalid_i = 1'b0;
      while (!axil_rvalid_o) @(negedge clk_i);
      got_data = axil_rdata_o;
      got_id   = axil_rid_o;
      got_resp = axil_rresp_o;
      if (offer) begin
         axil_awaddr_i  = addr;                       // Competing write.
         axil_awid_i    = ~id;
         axil_wdata_i   = ~addr;
         axil_wstrb_i   = 4'hf;
         axil_awvalid_i = 1'b1;
         axil_wvalid_i  = 1'b1;
      end
      repeat (delay) begin
         @(negedge clk_i);
         if (!axil_rvalid_o || axil_rdata_o !== got_data || axil_rid_o !== got_id)
            report_fail("read response changed while rready was low");
         if (axil_awready_o || axil_wready_o || axil_arready_o)
            report_fail("new address accepted while a read response was held");
      end
      axil_rready_i = 1'b1;
      @(negedge clk_i);
      axil_rready_i  = 1'b0;
      axil_awvalid_i = 1'b0;
      axil_wvalid_i  = 1'b0;
   endtask

   task automatic checked_access(input bit wr, input logic [31:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb, input logic [3:0] id, input bit offer);
      logic [31:0] got_data;
      logic [3:0]  got_id;
      logic [1:0]  got_resp;
      logic [31:0] e_data;
      logic [3:0]  e_id;
      logic [1:0]  e_resp;
      got_data = '0;                                  // Writes carry no data back.
      if (wr) axil_write(addr, data, strb, id, offer, got_id, got_resp);
      else    axil_read(addr, id, offer, got_data, got_id, got_resp);
      ref_model(wr, addr, data, strb, id, e_data, e_resp, e_id);
      exp_data_q.push_back(e_data);
      exp_id_q.push_back(e_id);
      exp_resp_q.push_back(e_resp);
      act_data_q.push_back(got_data);
      act_id_q.push_back(got_id);
      act_resp_q.push_back(got_resp);
      -> resp_ev;
   endtask

   task automatic scratch_pair(input bit offer);
      logic [3:0]  idx;
      logic [3:0]  strb;
      logic [31:0] data;
      logic [3:0]  wid;
      logic [3:0]  rid;
      idx  = rand_bits(4);                            // 8 to 15 alias.
      strb = rand_bits(4);
      data = rand_bits(32);
      wid  = rand_bits(4);
      rid  = rand_bits(4);
      if (strb == '0) strb = 4'hf;                    // Zero strobe means read on IOb.
      checked_access(1'b1, make_addr(REGION_REGS, idx), data, strb, wid, offer);
      checked_access(1'b0, make_addr(REGION_REGS, idx), '0, '0, rid, offer);
   endtask

   task automatic timer_write(input logic [3:0] idx, input logic [31:0] data);
      logic [3:0] got_id;
      logic [1:0] got_resp;
      axil_write(make_addr(REGION_TIMER, idx), data, 4'hf, idx, 1'b0, got_id, got_resp);
   endtask

   task automatic timer_read(input logic [3:0] idx, output logic [31:0] data);
      logic [3:0] got_id;
      logic [1:0] got_resp;
      axil_read(make_addr(REGION_TIMER, idx), idx, 1'b0, data, got_id, got_resp);
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_err0 = err_cnt;
   endtask

   task automatic end_test();
      @(negedge clk_i);                               // Compare process catches up.
      tests_run++;
      if (err_cnt == test_err0) begin
         $display("Test %-12s passed", cur_test);
      end else begin
         tests_failed++;
         $display("Test %-12s failed, %0d errors", cur_test, err_cnt - test_err0);
      end
   endtask

   // Compare process.
   initial begin
      forever begin
         @(resp_ev);
         while (act_data_q.size() != 0) begin
            checks++;
            if (act_data_q[0] !== exp_data_q[0]) report_value("data", exp_data_q[0], act_data_q[0]);
            if (act_id_q[0] !== exp_id_q[0]) report_value("id", exp_id_q[0], act_id_q[0]);
            if (act_resp_q[0] !== exp_resp_q[0]) report_value("resp", exp_resp_q[0], act_resp_q[0]);
            exp_data_q.delete(0);
            exp_id_q.delete(0);
            exp_resp_q.delete(0);
            act_data_q.delete(0);
            act_id_q.delete(0);
            act_resp_q.delete(0);
         end
      end
   end

   // Watchdog.
   initial begin
      #(CLK_PERIOD * WD_CYCLES);
      $display("Run timed out after %0d cycles, a transaction never completed", WD_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      logic [31:0] d;
      logic [31:0] c0;
      logic [31:0] c1;
      logic [3:0]  idx;
      int          polls;
      {axil_awid_i, axil_awaddr_i, axil_awprot_i, axil_awqos_i} = '0;
      {axil_arid_i, axil_araddr_i, axil_arprot_i, axil_arqos_i} = '0;
      {axil_wdata_i, axil_wstrb_i} = '0;
      {axil_awvalid_i, axil_wvalid_i, axil_arvalid_i} = '0;
      {axil_bready_i, axil_rready_i} = '0;
      {err_cnt, tests_run, tests_failed, checks} = '0;
      for (int i = 0; i < REG_N; i++) ref_mem[i] = '0;
      reset_i = 1'b1;
      repeat (2) @(negedge clk_i);                    // Two reset cycles.
      reset_i = 1'b0;

      start_test("reset");
      if (axil_bvalid_o !== 1'b0 || axil_rvalid_o !== 1'b0)
         report_fail("response valid high before any request");
      for (int i = 0; i < REG_N; i++) begin
         idx = i;
         checked_access(1'b0, make_addr(REGION_REGS, idx), '0, '0, idx, 1'b0);
      end
      timer_read(TMR_COUNT, d);
      if (d !== 32'd0) report_value("count", 32'd0, d);
      timer_read(TMR_STAT, d);
      if (d !== 32'd0) report_value("stat", 32'd0, d);
      end_test();

      start_test("scratch");
      repeat (64) scratch_pair(1'b0);
      end_test();

      start_test("backpressure");
      repeat (8) scratch_pair(1'b1);                  // Competing requests offered.
      end_test();

      start_test("unmapped");
      for (int i = 0; i < REG_N; i++) begin
         idx = i;
         checked_access(1'b1, make_addr(4'd5, idx), rand_bits(32), 4'hf, idx, 1'b0);
      end
      for (int i = 0; i < REG_N; i++) begin
         idx = i;
         checked_access(1'b0, make_addr(REGION_REGS, idx), '0, '0, idx, 1'b0);
      end
      for (int i = 0; i < 4; i++) begin
         idx = i;
         checked_access(1'b0, make_addr(4'd5, idx), '0, '0, idx, 1'b0);
      end
      end_test();

      start_test("timer_ctrl");
      timer_write(TMR_CTRL, 32'd2);                   // Clear, stay disabled.
      timer_read(TMR_COUNT, d);
      if (d !== 32'd0) report_value("cleared count", 32'd0, d);
      timer_write(TMR_CTRL, 32'd1);
      timer_read(TMR_COUNT, c0);
      timer_read(TMR_COUNT, c1);
      if (c1 <= c0) report_value("running count", c0 + 1, c1);
      timer_read(TMR_CTRL, d);
      if (d !== 32'd1) report_value("ctrl enabled", 32'd1, d);
      timer_write(TMR_CTRL, 32'd0);
      timer_read(TMR_COUNT, c0);
      timer_read(TMR_COUNT, c1);
      if (c1 !== c0) report_value("stopped count", c0, c1);
      timer_read(TMR_CTRL, d);
      if (d !== 32'd0) report_value("ctrl disabled", 32'd0, d);
      end_test();

      start_test("timer_match");
      timer_write(TMR_CMP, 32'd10);
      timer_write(TMR_STAT, 32'd1);                   // Drop any earlier match.
      timer_write(TMR_CTRL, 32'd3);                   // Clear and enable.
      polls = 0;
      d     = '0;
      while (d[0] !== 1'b1 && polls < 50) begin
         timer_read(TMR_STAT, d);
         polls++;
      end
      if (d[0] !== 1'b1) report_fail("match flag not set within 50 polls");
      timer_write(TMR_CMP, 32'hffff_0000);
      timer_write(TMR_STAT, 32'd1);
      timer_read(TMR_STAT, d);
      if (d !== 32'd0) report_value("stat after clear", 32'd0, d);
      end_test();

      $display("Summary: %0d tests, %0d failed, %0d responses compared, %0d errors",
               tests_run, tests_failed, checks, err_cnt);
      if (err_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
axil_pkg.sv
iob_pkg.sv
axil2iob.sv
iob_addr_decode.sv
iob_reg_bank.sv
iob_timer.sv
iob_rdata_mux.sv
axil_regs_top.sv
tb_axil_regs.sv
